/* rtl/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data word of the integer datapath
`define EXEC_DATA_W 32

// register-file write address
`define EXEC_REG_ADDR_W 5

// shift amount, low bits of operand A
`define EXEC_SHAMT_W 5

`endif

/* rtl/exec_pkg.sv */
package exec_pkg;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    // source of the register write data
    typedef enum logic [2:0] {
        RES_NONE,
        RES_LOGIC,
        RES_ARITH,
        RES_MUL,
        RES_HI,
        RES_LO
    } res_sel_e;

    typedef enum logic [2:0] {
        HILO_KEEP,
        HILO_LOAD,
        HILO_ACC,
        HILO_SUB,
        HILO_HI,
        HILO_LO
    } hilo_sel_e;

    typedef enum logic [0:0] {
        ST_RUN,
        ST_ACC
    } ctrl_state_e;

endpackage

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  alu_op_e     alu_op_i,
    output logic        stall_o,
    output res_sel_e    res_sel_o,
    output hilo_sel_e   hilo_sel_o,
    output logic        ovf_check_o,
    output logic        wb_load_o,
    output logic        prod_load_o
);

    ctrl_state_e state_q;
    res_sel_e    dec_res;
    hilo_sel_e   dec_hilo;
    logic        dec_macc;
    logic        accept;
    hilo_sel_e   hold_hilo_q;

    always_comb begin
        dec_res  = RES_NONE;
        dec_hilo = HILO_KEEP;
        dec_macc = 1'b0;
        case (alu_op_i)
            OP_AND, OP_OR, OP_XOR, OP_NOR,
            OP_SLL, OP_SRL, OP_SRA: dec_res = RES_LOGIC;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: dec_res = RES_ARITH;
            OP_MUL: dec_res = RES_MUL;
            OP_MULT, OP_MULTU: dec_hilo = HILO_LOAD;
            OP_MADD, OP_MADDU: begin
                dec_hilo = HILO_ACC;
                dec_macc = 1'b1;
            end
            OP_MSUB, OP_MSUBU: begin
                dec_hilo = HILO_SUB;
                dec_macc = 1'b1;
            end
            OP_MFHI: dec_res = RES_HI;
            OP_MFLO: dec_res = RES_LO;
            OP_MTHI: dec_hilo = HILO_HI;
            OP_MTLO: dec_hilo = HILO_LO;
            default: dec_res = RES_NONE;
        endcase
    end

    assign accept  = valid_i && (state_q == ST_RUN);
    assign stall_o = (state_q == ST_ACC);

    // accumulate phase replays the held HI/LO select
    always_comb begin
        if (state_q == ST_ACC) begin
            res_sel_o   = RES_NONE;
            hilo_sel_o  = hold_hilo_q;
            wb_load_o   = 1'b1;
            ovf_check_o = 1'b0;
            prod_load_o = 1'b0;
        end else begin
            res_sel_o   = accept ? dec_res : RES_NONE;
            hilo_sel_o  = (accept && !dec_macc) ? dec_hilo : HILO_KEEP;
            wb_load_o   = accept && !dec_macc;
            ovf_check_o = accept && ((alu_op_i == OP_ADD) || (alu_op_i == OP_SUB));
            prod_load_o = accept && dec_macc;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_RUN;
            hold_hilo_q <= HILO_KEEP;
        end else if (state_q == ST_ACC) begin
            state_q <= ST_RUN;
        end else if (accept && dec_macc) begin
            state_q     <= ST_ACC;
            hold_hilo_q <= dec_hilo;
        end
    end

endmodule

/* rtl/alu_arith.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_arith import exec_pkg::*; (
    input  alu_op_e                  alu_op_i,
    input  logic [`EXEC_DATA_W-1:0]  operand_a_i,
    input  logic [`EXEC_DATA_W-1:0]  operand_b_i,
    output logic [`EXEC_DATA_W-1:0]  arith_res_o,
    output logic                     overflow_o
);

    localparam int CNT_W = $clog2(`EXEC_DATA_W) + 1;

    logic                    do_sub;
    logic [`EXEC_DATA_W-1:0] b_eff;
    logic [`EXEC_DATA_W-1:0] sum;
    logic                    b_sign;
    logic                    less_s;
    logic                    less_u;

    function automatic logic [CNT_W-1:0] lead_zeros(input logic [`EXEC_DATA_W-1:0] v);
        logic [CNT_W-1:0] cnt;
        logic             hit;
        cnt = '0;
        hit = 1'b0;
        for (int i = `EXEC_DATA_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign do_sub = (alu_op_i == OP_SUB) || (alu_op_i == OP_SUBU) || (alu_op_i == OP_SLT);
    assign b_eff  = do_sub ? (~operand_b_i + 1'b1) : operand_b_i;
    assign sum    = operand_a_i + b_eff;

    // sign of the effective addend, taken before negation so -MIN is handled
    assign b_sign     = do_sub ? ~operand_b_i[`EXEC_DATA_W-1] : operand_b_i[`EXEC_DATA_W-1];
    assign overflow_o = (operand_a_i[`EXEC_DATA_W-1] == b_sign) &&
                        (sum[`EXEC_DATA_W-1] != operand_a_i[`EXEC_DATA_W-1]);

    assign less_s = (operand_a_i[`EXEC_DATA_W-1] != operand_b_i[`EXEC_DATA_W-1]) ?
                    operand_a_i[`EXEC_DATA_W-1] : sum[`EXEC_DATA_W-1];
    assign less_u = operand_a_i < operand_b_i;

    always_comb begin
        case (alu_op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res_o = sum;
            OP_SLT:  arith_res_o = `EXEC_DATA_W'(less_s);
            OP_SLTU: arith_res_o = `EXEC_DATA_W'(less_u);
            OP_CLZ:  arith_res_o = `EXEC_DATA_W'(lead_zeros(operand_a_i));
            OP_CLO:  arith_res_o = `EXEC_DATA_W'(lead_zeros(~operand_a_i));
            default: arith_res_o = '0;
        endcase
    end

endmodule

/* rtl/alu_logic_shift.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_logic_shift import exec_pkg::*; (
    input  alu_op_e                  alu_op_i,
    input  logic [`EXEC_DATA_W-1:0]  operand_a_i,
    input  logic [`EXEC_DATA_W-1:0]  operand_b_i,
    output logic [`EXEC_DATA_W-1:0]  logic_res_o
);

    logic [`EXEC_SHAMT_W-1:0] shamt;

    // amount comes from rs, value from rt
    assign shamt = operand_a_i[`EXEC_SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            OP_AND:  logic_res_o = operand_a_i & operand_b_i;
            OP_OR:   logic_res_o = operand_a_i | operand_b_i;
            OP_XOR:  logic_res_o = operand_a_i ^ operand_b_i;
            OP_NOR:  logic_res_o = ~(operand_a_i | operand_b_i);
            OP_SLL:  logic_res_o = operand_b_i << shamt;
            OP_SRL:  logic_res_o = operand_b_i >> shamt;
            OP_SRA:  logic_res_o = $signed(operand_b_i) >>> shamt;
            default: logic_res_o = '0;
        endcase
    end

endmodule

/* rtl/mul_unit.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module mul_unit import exec_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       prod_load_i,
    input  alu_op_e                    alu_op_i,
    input  logic [`EXEC_DATA_W-1:0]    operand_a_i,
    input  logic [`EXEC_DATA_W-1:0]    operand_b_i,
    output logic [`EXEC_DATA_W-1:0]    mul_lo_o,
    output logic [2*`EXEC_DATA_W-1:0]  prod_o
);

    logic                      is_signed;
    logic                      negate;
    logic [`EXEC_DATA_W-1:0]   mag_a;
    logic [`EXEC_DATA_W-1:0]   mag_b;
    logic [2*`EXEC_DATA_W-1:0] mag_prod;
    logic [2*`EXEC_DATA_W-1:0] prod_comb;
    logic [2*`EXEC_DATA_W-1:0] prod_q;
    logic                      prod_held_q;

    always_comb begin
        case (alu_op_i)
            OP_MUL, OP_MULT, OP_MADD, OP_MSUB: is_signed = 1'b1;
            default: is_signed = 1'b0;
        endcase
    end

    // magnitude multiply, sign fixed up afterwards
    assign mag_a    = (is_signed && operand_a_i[`EXEC_DATA_W-1]) ? -operand_a_i : operand_a_i;
    assign mag_b    = (is_signed && operand_b_i[`EXEC_DATA_W-1]) ? -operand_b_i : operand_b_i;
    assign negate   = is_signed && (operand_a_i[`EXEC_DATA_W-1] ^ operand_b_i[`EXEC_DATA_W-1]);
    assign mag_prod = {{`EXEC_DATA_W{1'b0}}, mag_a} * {{`EXEC_DATA_W{1'b0}}, mag_b};
    assign prod_comb = negate ? -mag_prod : mag_prod;

    assign mul_lo_o = prod_comb[`EXEC_DATA_W-1:0];
    assign prod_o   = prod_held_q ? prod_q : prod_comb;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_held_q <= 1'b0;
        end else begin
            prod_held_q <= prod_load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_load_i) begin
            prod_q <= prod_comb;
        end
    end

endmodule

/* rtl/hilo_reg.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module hilo_reg import exec_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  hilo_sel_e                  hilo_sel_i,
    input  logic [2*`EXEC_DATA_W-1:0]  prod_i,
    input  logic [`EXEC_DATA_W-1:0]    operand_a_i,
    output logic [`EXEC_DATA_W-1:0]    hi_o,
    output logic [`EXEC_DATA_W-1:0]    lo_o
);

    logic [2*`EXEC_DATA_W-1:0] hilo;
    logic [2*`EXEC_DATA_W-1:0] acc_sum;
    logic [2*`EXEC_DATA_W-1:0] acc_diff;

    assign hilo     = {hi_o, lo_o};
    assign acc_sum  = hilo + prod_i;
    assign acc_diff = hilo - prod_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            case (hilo_sel_i)
                HILO_LOAD: begin
                    {hi_o, lo_o} <= prod_i;
                end
                HILO_ACC: begin
                    {hi_o, lo_o} <= acc_sum;
                end
                HILO_SUB: begin
                    {hi_o, lo_o} <= acc_diff;
                end
                // move-to writes touch one half only
                HILO_HI: hi_o <= operand_a_i;
                HILO_LO: lo_o <= operand_a_i;
                default: begin
                    hi_o <= hi_o;
                    lo_o <= lo_o;
                end
            endcase
        end
    end

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module wb_stage import exec_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         wb_load_i,
    input  logic                         ovf_check_i,
    input  logic                         overflow_i,
    input  logic                         wr_en_i,
    input  res_sel_e                     res_sel_i,
    input  logic [`EXEC_DATA_W-1:0]      logic_res_i,
    input  logic [`EXEC_DATA_W-1:0]      arith_res_i,
    input  logic [`EXEC_DATA_W-1:0]      mul_lo_i,
    input  logic [`EXEC_DATA_W-1:0]      hi_i,
    input  logic [`EXEC_DATA_W-1:0]      lo_i,
    input  logic [`EXEC_REG_ADDR_W-1:0]  wr_addr_i,
    output logic                         result_valid_o,
    output logic                         reg_wr_en_o,
    output logic                         overflow_o,
    output logic [`EXEC_REG_ADDR_W-1:0]  reg_wr_addr_o,
    output logic [`EXEC_DATA_W-1:0]      reg_wr_data_o
);

    logic [`EXEC_DATA_W-1:0] sel_data;
    logic                    ovf_hit;

    always_comb begin
        case (res_sel_i)
            RES_LOGIC: sel_data = logic_res_i;
            RES_ARITH: sel_data = arith_res_i;
            RES_MUL:   sel_data = mul_lo_i;
            RES_HI:    sel_data = hi_i;
            RES_LO:    sel_data = lo_i;
            default:   sel_data = '0;
        endcase
    end

    assign ovf_hit = ovf_check_i && overflow_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            reg_wr_en_o    <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            result_valid_o <= wb_load_i;
            reg_wr_en_o    <= wb_load_i && wr_en_i && (res_sel_i != RES_NONE) && !ovf_hit;
            overflow_o     <= wb_load_i && ovf_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_load_i) begin
            reg_wr_addr_o <= wr_addr_i;
            reg_wr_data_o <= sel_data;
        end
    end

endmodule

/* rtl/exec_unit.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_unit import exec_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         valid_i,
    input  logic                         wr_en_i,
    input  alu_op_e                      alu_op_i,
    input  logic [`EXEC_DATA_W-1:0]      operand_a_i,
    input  logic [`EXEC_DATA_W-1:0]      operand_b_i,
    input  logic [`EXEC_REG_ADDR_W-1:0]  wr_addr_i,
    output logic                         stall_o,
    output logic                         result_valid_o,
    output logic                         reg_wr_en_o,
    output logic                         overflow_o,
    output logic [`EXEC_REG_ADDR_W-1:0]  reg_wr_addr_o,
    output logic [`EXEC_DATA_W-1:0]      reg_wr_data_o
);

    res_sel_e                  res_sel;
    hilo_sel_e                 hilo_sel;
    logic                      ovf_check;
    logic                      wb_load;
    logic                      prod_load;
    logic [2*`EXEC_DATA_W-1:0] prod;
    logic [`EXEC_DATA_W-1:0]   mul_lo;
    logic [`EXEC_DATA_W-1:0]   arith_res;
    logic                      overflow;
    logic [`EXEC_DATA_W-1:0]   logic_res;
    logic [`EXEC_DATA_W-1:0]   hi;
    logic [`EXEC_DATA_W-1:0]   lo;

    exec_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .alu_op_i    (alu_op_i),
        .stall_o     (stall_o),
        .res_sel_o   (res_sel),
        .hilo_sel_o  (hilo_sel),
        .ovf_check_o (ovf_check),
        .wb_load_o   (wb_load),
        .prod_load_o (prod_load)
    );

    alu_arith u_arith (
        .alu_op_i    (alu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .arith_res_o (arith_res),
        .overflow_o  (overflow)
    );

    alu_logic_shift u_logic (
        .alu_op_i    (alu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .logic_res_o (logic_res)
    );

    mul_unit u_mul (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .prod_load_i (prod_load),
        .alu_op_i    (alu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .mul_lo_o    (mul_lo),
        .prod_o      (prod)
    );

    hilo_reg u_hilo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hilo_sel_i  (hilo_sel),
        .prod_i      (prod),
        .operand_a_i (operand_a_i),
        .hi_o        (hi),
        .lo_o        (lo)
    );

    wb_stage u_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_load_i      (wb_load),
        .ovf_check_i    (ovf_check),
        .overflow_i     (overflow),
        .wr_en_i        (wr_en_i),
        .res_sel_i      (res_sel),
        .logic_res_i    (logic_res),
        .arith_res_i    (arith_res),
        .mul_lo_i       (mul_lo),
        .hi_i           (hi),
        .lo_i           (lo),
        .wr_addr_i      (wr_addr_i),
        .result_valid_o (result_valid_o),
        .reg_wr_en_o    (reg_wr_en_o),
        .overflow_o     (overflow_o),
        .reg_wr_addr_o  (reg_wr_addr_o),
        .reg_wr_data_o  (reg_wr_data_o)
    );

endmodule

/* tests/exec_checker.sv */
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input logic    clk,
    input logic    rst_n_i,
    input logic    valid_i,
    input alu_op_e alu_op_i,
    input logic    stall_o,
    input logic    result_valid_o,
    input logic    reg_wr_en_o
);

    logic single_acc;
    logic macc_acc;
    int   fail_cnt = 0;

    assign single_acc = valid_i && !stall_o &&
                        !(alu_op_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU});
    assign macc_acc   = valid_i && !stall_o &&
                        (alu_op_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU});

    stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o)
        else begin
            fail_cnt++;
            $error("stall_o high on two consecutive cycles");
        end

    result_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
        single_acc |=> result_valid_o)
        else begin
            fail_cnt++;
            $error("result_valid_o missing one cycle after acceptance");
        end

    // accumulate result lands two cycles after acceptance, no register write
    macc_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(macc_acc, 2) |-> (result_valid_o && !reg_wr_en_o))
        else begin
            fail_cnt++;
            $error("accumulate result not pulsed two cycles after acceptance");
        end

endmodule

/* tests/exec_monitor.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_monitor import exec_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         valid_i,
    input  logic                         wr_en_i,
    input  alu_op_e                      alu_op_i,
    input  logic [`EXEC_DATA_W-1:0]      operand_a_i,
    input  logic [`EXEC_DATA_W-1:0]      operand_b_i,
    input  logic [`EXEC_REG_ADDR_W-1:0]  wr_addr_i,
    input  logic                         stall_o,
    input  logic                         result_valid_o,
    input  logic                         reg_wr_en_o,
    input  logic                         overflow_o,
    input  logic [`EXEC_REG_ADDR_W-1:0]  reg_wr_addr_o,
    input  logic [`EXEC_DATA_W-1:0]      reg_wr_data_o,
    input  logic                         test_end_i,
    input  int                           test_idx_i,
    output int                           check_cnt_o,
    output int                           err_cnt_o
);

    typedef struct packed {
        logic        valid;
        logic        we;
        logic        ovf;
        logic [4:0]  addr;
        logic [31:0] data;
    } exp_t;

    exp_t        due1;
    exp_t        due2;
    exp_t        cur;
    logic        stall_due;
    logic        stall_exp;
    logic [31:0] hi_m;
    logic [31:0] lo_m;
    int          checks;
    int          errs;
    int          last_checks;
    int          last_errs;

    assign check_cnt_o = checks;
    assign err_cnt_o   = errs;

    initial begin
        checks      = 0;
        errs        = 0;
        last_checks = 0;
        last_errs   = 0;
    end

    function automatic string name_of(input int t);
        case (t)
            0: return "reset state";
            1: return "logic and shift";
            2: return "add, sub, compare, count";
            3: return "multiply";
            4: return "multiply-accumulate";
            default: return "hi/lo moves";
        endcase
    endfunction

    function automatic logic [31:0] count_lead(input logic [31:0] v, input logic b);
        int n;
        n = 0;
        while (n < 32 && v[31-n] == b) n++;
        return 32'(n);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errs++;
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic report_problem(input string what);
        checks++;
        errs++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic check_result(input exp_t e);
        if (e.valid) begin
            if (!result_valid_o) begin
                report_problem("expected a result_valid_o pulse but none came");
            end else begin
                check_value("reg_wr_en_o", 32'(e.we), 32'(reg_wr_en_o));
                check_value("overflow_o", 32'(e.ovf), 32'(overflow_o));
                if (e.we && reg_wr_en_o) begin
                    check_value("reg_wr_addr_o", 32'(e.addr), 32'(reg_wr_addr_o));
                    check_value("reg_wr_data_o", e.data, reg_wr_data_o);
                end
            end
        end else begin
            if (result_valid_o) report_problem("result_valid_o pulsed with no operation pending");
            check_value("reg_wr_en_o", 32'h0, 32'(reg_wr_en_o));
            check_value("overflow_o", 32'h0, 32'(overflow_o));
        end
    endtask

    // model of one accepted operation
    task automatic record_op();
        exp_t              e;
        logic [63:0]       sp;
        logic [63:0]       up;
        logic signed [32:0] wide;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic              has_res;
        logic              ovf;
        a       = operand_a_i;
        b       = operand_b_i;
        sp      = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        up      = {32'h0, a} * {32'h0, b};
        res     = '0;
        has_res = 1'b1;
        ovf     = 1'b0;
        case (alu_op_i)
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            OP_SLL:  res = b << a[4:0];
            OP_SRL:  res = b >> a[4:0];
            OP_SRA:  res = $signed(b) >>> a[4:0];
            OP_ADD, OP_SUB: begin
                if (alu_op_i == OP_ADD) wide = $signed({a[31], a}) + $signed({b[31], b});
                else wide = $signed({a[31], a}) - $signed({b[31], b});
                res = wide[31:0];
                ovf = wide[32] ^ wide[31];
            end
            OP_ADDU: res = a + b;
            OP_SUBU: res = a - b;
            OP_SLT:  res = {31'h0, $signed(a) < $signed(b)};
            OP_SLTU: res = {31'h0, a < b};
            OP_CLZ:  res = count_lead(a, 1'b0);
            OP_CLO:  res = count_lead(a, 1'b1);
            OP_MUL:  res = sp[31:0];
            OP_MFHI: res = hi_m;
            OP_MFLO: res = lo_m;
            default: has_res = 1'b0;
        endcase
        case (alu_op_i)
            OP_MULT:  {hi_m, lo_m} = sp;
            OP_MULTU: {hi_m, lo_m} = up;
            OP_MADD:  {hi_m, lo_m} = {hi_m, lo_m} + sp;
            OP_MADDU: {hi_m, lo_m} = {hi_m, lo_m} + up;
            OP_MSUB:  {hi_m, lo_m} = {hi_m, lo_m} - sp;
            OP_MSUBU: {hi_m, lo_m} = {hi_m, lo_m} - up;
            OP_MTHI:  hi_m = a;
            OP_MTLO:  lo_m = a;
            default: ;
        endcase
        e.valid = 1'b1;
        e.we    = has_res && wr_en_i && !ovf;
        e.ovf   = ovf;
        e.addr  = wr_addr_i;
        e.data  = res;
        if (alu_op_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
            due2      = e;
            stall_due = 1'b1;
        end else begin
            due1 = e;
        end
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            due1      = '0;
            due2      = '0;
            stall_due = 1'b0;
            hi_m      = '0;
            lo_m      = '0;
        end else begin
            cur       = due1;
            due1      = due2;
            due2      = '0;
            stall_exp = stall_due;
            stall_due = 1'b0;
            check_value("stall_o", 32'(stall_exp), 32'(stall_o));
            check_result(cur);
            if (valid_i && !stall_o) record_op();
        end
    end

    always @(posedge test_end_i) begin
        $display("test %0d (%s): %0d checks, %0d errors", test_idx_i, name_of(test_idx_i),
                 checks - last_checks, errs - last_errs);
        last_checks = checks;
        last_errs   = errs;
    end

endmodule

/* tests/tb_exec_unit.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_exec_unit import exec_pkg::*; ();

    localparam int NUM_TESTS    = 6;
    localparam int OPS_PER_TEST = 200;
    localparam int CYCLE_LIMIT  = NUM_TESTS * OPS_PER_TEST * 2 + 600;

    logic                         clk;
    logic                         rst_n_i;
    logic                         valid_i;
    logic                         wr_en_i;
    alu_op_e                      alu_op_i;
    logic [`EXEC_DATA_W-1:0]      operand_a_i;
    logic [`EXEC_DATA_W-1:0]      operand_b_i;
    logic [`EXEC_REG_ADDR_W-1:0]  wr_addr_i;
    logic                         stall_o;
    logic                         result_valid_o;
    logic                         reg_wr_en_o;
    logic                         overflow_o;
    logic [`EXEC_REG_ADDR_W-1:0]  reg_wr_addr_o;
    logic [`EXEC_DATA_W-1:0]      reg_wr_data_o;
    logic                         test_end;
    int                           test_idx;
    int                           check_cnt;
    int                           err_cnt;
    int                           cycles;
    logic [31:0]                  lfsr_q;

    exec_unit UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .wr_en_i        (wr_en_i),
        .alu_op_i       (alu_op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .wr_addr_i      (wr_addr_i),
        .stall_o        (stall_o),
        .result_valid_o (result_valid_o),
        .reg_wr_en_o    (reg_wr_en_o),
        .overflow_o     (overflow_o),
        .reg_wr_addr_o  (reg_wr_addr_o),
        .reg_wr_data_o  (reg_wr_data_o)
    );

    exec_monitor u_monitor (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .wr_en_i        (wr_en_i),
        .alu_op_i       (alu_op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .wr_addr_i      (wr_addr_i),
        .stall_o        (stall_o),
        .result_valid_o (result_valid_o),
        .reg_wr_en_o    (reg_wr_en_o),
        .overflow_o     (overflow_o),
        .reg_wr_addr_o  (reg_wr_addr_o),
        .reg_wr_data_o  (reg_wr_data_o),
        .test_end_i     (test_end),
        .test_idx_i     (test_idx),
        .check_cnt_o    (check_cnt),
        .err_cnt_o      (err_cnt)
    );

    bind exec_unit exec_checker u_checker (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .alu_op_i       (alu_op_i),
        .stall_o        (stall_o),
        .result_valid_o (result_valid_o),
        .reg_wr_en_o    (reg_wr_en_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    function automatic alu_op_e pick_op(input int test, input logic [31:0] r);
        case (test)
            0: return r[0] ? OP_MFHI : OP_MFLO;
            1: return alu_op_e'(5'(int'(OP_AND) + int'(r % 7)));
            2: return alu_op_e'(5'(int'(OP_ADD) + int'(r % 8)));
            3: begin
                if (r % 5 < 3) return alu_op_e'(5'(int'(OP_MUL) + int'(r % 5)));
                return (r % 5 == 3) ? OP_MFHI : OP_MFLO;
            end
            4: begin
                if (r % 6 < 4) return alu_op_e'(5'(int'(OP_MADD) + int'(r % 6)));
                return (r % 6 == 4) ? OP_MFHI : OP_MFLO;
            end
            default: return alu_op_e'(5'(int'(OP_MFHI) + int'(r % 4)));
        endcase
    endfunction

    // inputs stay put until the DUT takes them
    task automatic wait_accept();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = !stall_o;
            @(posedge clk);
        end
    endtask

    task automatic issue_op(input int test);
        logic [31:0] a;
        a = rand_bits(32);
        // short operands so clz/clo and shifts see a spread of values
        if (rand_bits(1) != 0) a = a >> rand_bits(5);
        if (rand_bits(1) != 0) a = ~a;
        valid_i     <= 1'b1;
        alu_op_i    <= pick_op(test, rand_bits(8));
        operand_a_i <= a;
        operand_b_i <= rand_bits(32);
        wr_addr_i   <= 5'(rand_bits(5));
        wr_en_i     <= (rand_bits(3) != 0);
        wait_accept();
    endtask

    initial begin
        lfsr_q      = 32'hee87;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        wr_en_i     = 1'b0;
        alu_op_i    = OP_NOP;
        operand_a_i = '0;
        operand_b_i = '0;
        wr_addr_i   = '0;
        test_end    = 1'b0;
        test_idx    = 0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_idx <= t;
            for (int n = 0; n < OPS_PER_TEST; n++) begin
                issue_op(t);
            end
            valid_i <= 1'b0;
            repeat (4) @(posedge clk);
            test_end <= 1'b1;
            @(posedge clk);
            test_end <= 1'b0;
        end
        @(posedge clk);
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, check_cnt, err_cnt, UUT.u_checker.fail_cnt);
        if (err_cnt == 0 && UUT.u_checker.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("tests failed");
                $finish;
            end
        end
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_ctrl.sv
rtl/alu_arith.sv
rtl/alu_logic_shift.sv
rtl/mul_unit.sv
rtl/hilo_reg.sv
rtl/wb_stage.sv
rtl/exec_unit.sv
tests/exec_checker.sv
tests/exec_monitor.sv
tests/tb_exec_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
